// File: src/fetch_geom_pkg.sv
/*
 * address and line geometry of the 128-bit instruction memory
 * line memory request and response structs
 */
package fetch_geom_pkg;

  //////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////

  localparam int ADDR_W          = 32;
  localparam int LINE_BYTES      = 16;
  localparam int HWORDS_PER_LINE = 8;
  localparam int LINE_OFS_W      = 4;   // byte offset within a line

  // line slots in the queue, equal to the number of request credits
  localparam int QUEUE_DEPTH     = 2;
  localparam int SLOT_CNT_W      = $clog2(QUEUE_DEPTH + 1);

  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [ADDR_W-LINE_OFS_W-1:0] line_addr_t;   // line number
  typedef logic [SLOT_CNT_W-1:0]        slot_cnt_t;    // credit and request counters

  // one line as halfwords, halfword 0 at the lowest address
  typedef logic [HWORDS_PER_LINE-1:0][(LINE_BYTES/HWORDS_PER_LINE)*8-1:0] line_t;

  //////////////////////////////////////////////////////////////
  // memory port
  //////////////////////////////////////////////////////////////

  // held by the requester until gnt is seen with it
  typedef struct packed {
    logic       req;
    line_addr_t line_addr;
  } mem_req_t;

  // responses come back in order, marked by rvalid
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    line_t rdata;
  } mem_rsp_t;

endpackage

// File: src/rv_instr_pkg.sv
/*
 * instruction encoding constants
 * core-side instruction transfer struct
 */
package rv_instr_pkg;

  localparam int HWORD_W = 16;
  localparam int INSTR_W = 32;

  // low opcode bits of a 32-bit instruction, anything else is compressed
  localparam logic [1:0] OPC_FULL = 2'b11;

  typedef logic [HWORD_W-1:0] hword_t;
  typedef logic [INSTR_W-1:0] instr_t;

  // one instruction towards the core
  typedef struct packed {
    logic                  valid;
    instr_t                data;  // compressed ones are zero extended
    fetch_geom_pkg::addr_t addr;
  } fetch_out_t;

endpackage

// File: src/line_fetch_ctrl.sv
/*
 * line fetch controller
 * issues line requests against queue credits and drops stale responses after a branch
 */
`timescale 1ns/100ps

module line_fetch_ctrl (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       branch_i,
  input  fetch_geom_pkg::addr_t      branch_addr_i,

  input  logic                       credit_return_i,  // one pulse per popped line

  output fetch_geom_pkg::mem_req_t   mem_req_o,
  input  fetch_geom_pkg::mem_rsp_t   mem_rsp_i,

  output logic                       push_o,
  output fetch_geom_pkg::line_t      push_line_o,
  output fetch_geom_pkg::line_addr_t push_addr_o,

  output logic                       busy_o
);

  logic                       armed_q;      // set by the first branch
  fetch_geom_pkg::line_addr_t line_q;       // next line to request
  fetch_geom_pkg::line_addr_t rsp_line_q;   // line of the next live response
  fetch_geom_pkg::slot_cnt_t  credits_q;
  fetch_geom_pkg::slot_cnt_t  inflight_q;   // granted, unanswered, still wanted
  fetch_geom_pkg::slot_cnt_t  discard_q;    // responses still owed to an old stream

  fetch_geom_pkg::line_addr_t branch_line;
  logic                       gnt_fire;
  logic                       rsp_fire;
  logic                       drop;

  assign branch_line = branch_addr_i[fetch_geom_pkg::ADDR_W-1:fetch_geom_pkg::LINE_OFS_W];

  //////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////

  // stale requests still out count against the credits, which keeps the
  // total of outstanding requests and held lines within the queue depth
  always_comb begin
    mem_req_o           = '0;
    mem_req_o.req       = armed_q && (credits_q > discard_q);
    mem_req_o.line_addr = line_q;
  end

  assign gnt_fire = mem_req_o.req && mem_rsp_i.gnt;

  //////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////

  assign rsp_fire = mem_rsp_i.rvalid;
  assign drop     = (discard_q != '0);  // oldest responses belong to the old stream

  assign push_o      = rsp_fire && !drop && !branch_i;  // queue is flushed in a branch cycle
  assign push_line_o = mem_rsp_i.rdata;
  assign push_addr_o = rsp_line_q;

  assign busy_o = mem_req_o.req || (inflight_q != '0) || (discard_q != '0);

  //////////////////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed_q    <= 1'b0;
      line_q     <= '0;
      rsp_line_q <= '0;
      credits_q  <= fetch_geom_pkg::slot_cnt_t'(fetch_geom_pkg::QUEUE_DEPTH);
      inflight_q <= '0;
      discard_q  <= '0;
    end else if (branch_i) begin
      armed_q    <= 1'b1;
      line_q     <= branch_line;
      rsp_line_q <= branch_line;
      credits_q  <= fetch_geom_pkg::slot_cnt_t'(fetch_geom_pkg::QUEUE_DEPTH);
      inflight_q <= '0;
      // everything still out, including a grant in this cycle, is now stale
      discard_q  <= discard_q + inflight_q
                    + fetch_geom_pkg::slot_cnt_t'(gnt_fire)
                    - fetch_geom_pkg::slot_cnt_t'(rsp_fire);
    end else begin
      if (gnt_fire) begin
        line_q <= line_q + 1'b1;
      end
      if (push_o) begin
        rsp_line_q <= rsp_line_q + 1'b1;
      end
      credits_q  <= credits_q
                    - fetch_geom_pkg::slot_cnt_t'(gnt_fire)
                    + fetch_geom_pkg::slot_cnt_t'(credit_return_i);
      inflight_q <= inflight_q
                    + fetch_geom_pkg::slot_cnt_t'(gnt_fire)
                    - fetch_geom_pkg::slot_cnt_t'(rsp_fire && !drop);
      discard_q  <= discard_q - fetch_geom_pkg::slot_cnt_t'(rsp_fire && drop);
    end
  end

endmodule

// File: src/line_queue.sv
/*
 * two-entry ordered queue of fetched lines and their line numbers
 * returns one credit per pop
 */
`timescale 1ns/100ps

module line_queue (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       flush_i,

  input  logic                       push_i,
  input  fetch_geom_pkg::line_t      push_line_i,
  input  fetch_geom_pkg::line_addr_t push_addr_i,

  input  logic                       pop_i,

  output fetch_geom_pkg::line_t      head_o,
  output fetch_geom_pkg::line_t      second_o,
  output fetch_geom_pkg::line_addr_t head_addr_o,
  output logic                       head_valid_o,
  output logic                       second_valid_o,

  output logic                       credit_return_o
);

  fetch_geom_pkg::line_t      head_line_q, head_line_n;
  fetch_geom_pkg::line_addr_t head_addr_q, head_addr_n;
  logic                       head_valid_q, head_valid_n;
  fetch_geom_pkg::line_t      sec_line_q, sec_line_n;
  fetch_geom_pkg::line_addr_t sec_addr_q, sec_addr_n;
  logic                       sec_valid_q, sec_valid_n;

  logic                       pop_fire;

  assign pop_fire        = pop_i && head_valid_q;
  assign credit_return_o = pop_fire && !flush_i;  // controller reloads credits on flush

  // pop first, then the pushed line fills the first free slot
  always_comb begin
    head_line_n  = head_line_q;
    head_addr_n  = head_addr_q;
    head_valid_n = head_valid_q;
    sec_line_n   = sec_line_q;
    sec_addr_n   = sec_addr_q;
    sec_valid_n  = sec_valid_q;

    if (pop_fire) begin
      head_line_n  = sec_line_q;
      head_addr_n  = sec_addr_q;
      head_valid_n = sec_valid_q;
      sec_valid_n  = 1'b0;
    end

    if (push_i) begin
      if (!head_valid_n) begin
        head_line_n  = push_line_i;
        head_addr_n  = push_addr_i;
        head_valid_n = 1'b1;
      end else begin
        sec_line_n  = push_line_i;
        sec_addr_n  = push_addr_i;
        sec_valid_n = 1'b1;
      end
    end

    if (flush_i) begin
      head_valid_n = 1'b0;
      sec_valid_n  = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_valid_q <= 1'b0;
      sec_valid_q  <= 1'b0;
    end else begin
      head_valid_q <= head_valid_n;
      sec_valid_q  <= sec_valid_n;
    end
  end

  // line payload
  always_ff @(posedge clk) begin
    head_line_q <= head_line_n;
    head_addr_q <= head_addr_n;
    sec_line_q  <= sec_line_n;
    sec_addr_q  <= sec_addr_n;
  end

  assign head_o         = head_line_q;
  assign second_o       = sec_line_q;
  assign head_addr_o    = head_addr_q;
  assign head_valid_o   = head_valid_q;
  assign second_valid_o = sec_valid_q;

endmodule

// File: src/instr_aligner.sv
/*
 * instruction aligner holding the program counter
 * extracts aligned, unaligned and line-crossing instructions from the queued lines
 */
`timescale 1ns/100ps

module instr_aligner (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       branch_i,
  input  fetch_geom_pkg::addr_t      branch_addr_i,

  input  fetch_geom_pkg::line_t      head_i,
  input  fetch_geom_pkg::line_t      second_i,
  input  fetch_geom_pkg::line_addr_t head_addr_i,
  input  logic                       head_valid_i,
  input  logic                       second_valid_i,

  input  logic                       ready_i,
  output rv_instr_pkg::fetch_out_t   fetch_o,

  output logic                       pop_o   // pc leaves the head line
);

  localparam int HW_IDX_W = fetch_geom_pkg::LINE_OFS_W - 1;

  fetch_geom_pkg::addr_t      pc_q;
  fetch_geom_pkg::addr_t      pc_next;
  fetch_geom_pkg::line_addr_t pc_line;
  logic [HW_IDX_W-1:0]        hw_idx;
  logic                       last_hw;

  rv_instr_pkg::hword_t       lo_hw;
  rv_instr_pkg::hword_t       hi_hw;
  logic                       is_full;
  logic                       crosses;
  logic                       valid;
  logic                       transfer;

  assign pc_line = pc_q[fetch_geom_pkg::ADDR_W-1:fetch_geom_pkg::LINE_OFS_W];
  assign hw_idx  = pc_q[fetch_geom_pkg::LINE_OFS_W-1:1];
  assign last_hw = (hw_idx == HW_IDX_W'(fetch_geom_pkg::HWORDS_PER_LINE - 1));

  //////////////////////////////////////////////////////////////
  // halfword selection
  //////////////////////////////////////////////////////////////

  assign lo_hw = head_i[hw_idx];

  // upper half comes from the next line when pc sits on the last halfword
  always_comb begin
    if (last_hw) begin
      hi_hw = second_i[0];
    end else begin
      hi_hw = head_i[hw_idx + 1'b1];
    end
  end

  assign is_full = (lo_hw[1:0] == rv_instr_pkg::OPC_FULL);
  assign crosses = is_full && last_hw;  // needs the second line as well

  // head must hold the pc's line, no stale line survives a flush
  assign valid = head_valid_i && (head_addr_i == pc_line)
                 && (!crosses || second_valid_i);

  //////////////////////////////////////////////////////////////
  // core side
  //////////////////////////////////////////////////////////////

  always_comb begin
    fetch_o       = '0;
    fetch_o.valid = valid && !branch_i;   // branch wins
    fetch_o.addr  = pc_q;
    if (is_full) begin
      fetch_o.data = {hi_hw, lo_hw};
    end else begin
      fetch_o.data = {{rv_instr_pkg::HWORD_W{1'b0}}, lo_hw};
    end
  end

  assign transfer = fetch_o.valid && ready_i;

  assign pc_next = pc_q + (is_full ? fetch_geom_pkg::addr_t'(4) : fetch_geom_pkg::addr_t'(2));

  // head line is done once the new pc falls in the following line
  assign pop_o = transfer
                 && (pc_next[fetch_geom_pkg::ADDR_W-1:fetch_geom_pkg::LINE_OFS_W] != pc_line);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (branch_i) begin
      pc_q <= {branch_addr_i[fetch_geom_pkg::ADDR_W-1:1], 1'b0};  // halfword aligned
    end else if (transfer) begin
      pc_q <= pc_next;
    end
  end

endmodule

// File: src/prefetch_buffer.sv
/*
 * instruction prefetch buffer top
 * line fetch controller, two-line queue and instruction aligner
 */
`timescale 1ns/100ps

module prefetch_buffer (
  input  logic                     clk,
  input  logic                     rst_n,

  // core side
  input  logic                     branch_i,
  input  fetch_geom_pkg::addr_t    branch_addr_i,
  input  logic                     ready_i,
  output rv_instr_pkg::fetch_out_t fetch_o,

  // instruction memory
  output fetch_geom_pkg::mem_req_t mem_req_o,
  input  fetch_geom_pkg::mem_rsp_t mem_rsp_i,

  output logic                     busy_o
);

  logic                       credit_return;
  logic                       push;
  fetch_geom_pkg::line_t      push_line;
  fetch_geom_pkg::line_addr_t push_addr;

  fetch_geom_pkg::line_t      head;
  fetch_geom_pkg::line_t      second;
  fetch_geom_pkg::line_addr_t head_addr;
  logic                       head_valid;
  logic                       second_valid;
  logic                       pop;

  line_fetch_ctrl u_fetch_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .credit_return_i (credit_return),
    .mem_req_o       (mem_req_o),
    .mem_rsp_i       (mem_rsp_i),
    .push_o          (push),
    .push_line_o     (push_line),
    .push_addr_o     (push_addr),
    .busy_o          (busy_o)
  );

  // a branch flushes the queued lines
  line_queue u_line_queue (
    .clk             (clk),
    .rst_n           (rst_n),
    .flush_i         (branch_i),
    .push_i          (push),
    .push_line_i     (push_line),
    .push_addr_i     (push_addr),
    .pop_i           (pop),
    .head_o          (head),
    .second_o        (second),
    .head_addr_o     (head_addr),
    .head_valid_o    (head_valid),
    .second_valid_o  (second_valid),
    .credit_return_o (credit_return)
  );

  instr_aligner u_aligner (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .head_i          (head),
    .second_i        (second),
    .head_addr_i     (head_addr),
    .head_valid_i    (head_valid),
    .second_valid_i  (second_valid),
    .ready_i         (ready_i),
    .fetch_o         (fetch_o),
    .pop_o           (pop)
  );

endmodule

// File: testbench/tb_prefetch_buffer.sv
/*
 * testbench for the instruction prefetch buffer
 * line memory model, stimulus table, image walk checks and watchdog
 */
`timescale 1ns/100ps

module tb_prefetch_buffer;

  localparam int NUM_ROWS = 8;

  // first_len is the byte size of the instruction at the target
  typedef struct packed {
    fetch_geom_pkg::addr_t target;
    logic [7:0]            count;      // instructions to accept
    logic [7:0]            ready_pct;
    logic [3:0]            lat;        // max grant and rvalid delay
    logic                  stall;      // wait for idle before the next branch
    logic [2:0]            first_len;
  } row_t;

  row_t rows [NUM_ROWS] = '{
    '{32'h0000_1000, 8'd40, 8'd100, 4'd0, 1'b1, 3'd2},
    '{32'h0000_2040, 8'd40, 8'd100, 4'd3, 1'b1, 3'd2},
    '{32'h0000_300e, 8'd12, 8'd100, 4'd2, 1'b1, 3'd4},  // 32-bit on the last halfword
    '{32'h0000_4004, 8'd40, 8'd40,  4'd2, 1'b1, 3'd4},
    '{32'h0000_5000, 8'd10, 8'd100, 4'd4, 1'b0, 3'd2},  // next branch hits mid-stream
    '{32'h0000_6006, 8'd30, 8'd70,  4'd4, 1'b0, 3'd4},
    '{32'h0000_7ffe, 8'd20, 8'd50,  4'd1, 1'b0, 3'd4},
    '{32'h0001_0002, 8'd48, 8'd80,  4'd3, 1'b1, 3'd2}
  };
  string row_names [NUM_ROWS] = '{"seq_aligned", "seq_slow_mem", "unaligned_last",
    "backpressure", "branch_early", "midstream_tgt", "unaligned_bp", "long_tail"};

  logic                     clk;
  logic                     rst_n;
  logic                     branch_i;
  fetch_geom_pkg::addr_t    branch_addr_i;
  logic                     ready_i;
  rv_instr_pkg::fetch_out_t fetch_o;
  fetch_geom_pkg::mem_req_t mem_req_o;
  fetch_geom_pkg::mem_rsp_t mem_rsp_i;
  logic                     busy_o;

  int unsigned cycle;
  int unsigned errors;
  int unsigned checks;
  string       cur_name;
  int unsigned cur_count;
  int unsigned cur_pct;
  int unsigned cur_lat;
  int unsigned cur_first_len;

  logic                       armed;       // first branch seen
  fetch_geom_pkg::addr_t      exp_pc;      // walk through the image
  fetch_geom_pkg::line_addr_t exp_req_line; // next line the stream asks for
  int unsigned                accepted;
  int                         held;        // live lines in the queue
  logic                       first_xfer;
  int unsigned                stream_id;
  logic                       hold_prev;
  rv_instr_pkg::fetch_out_t   fetch_prev;
  logic                       busy_seen;
  int unsigned                gnt_wait;

  // granted requests in order: line, cycle of its response, stream
  fetch_geom_pkg::line_addr_t pend_line [$];
  int unsigned                pend_due [$];
  int unsigned                pend_id [$];

  prefetch_buffer DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .ready_i       (ready_i),
    .fetch_o       (fetch_o),
    .mem_req_o     (mem_req_o),
    .mem_rsp_i     (mem_rsp_i),
    .busy_o        (busy_o)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////
  // instruction image
  //////////////////////////////////////////////////////////////

  // bit 2 of the address picks a 32-bit opcode, else compressed
  function automatic rv_instr_pkg::hword_t image_hword(fetch_geom_pkg::addr_t a);
    rv_instr_pkg::hword_t h;
    h      = a[15:0] ^ a[31:16] ^ {a[8:1], a[16:9]} ^ 16'h9e37;
    h[1:0] = a[2] ? rv_instr_pkg::OPC_FULL : 2'b01;
    return h;
  endfunction

  function automatic fetch_geom_pkg::line_t line_data(fetch_geom_pkg::line_addr_t la);
    fetch_geom_pkg::line_t l;
    for (int i = 0; i < fetch_geom_pkg::HWORDS_PER_LINE; i++) begin
      l[i] = image_hword({la, 4'h0} + fetch_geom_pkg::addr_t'(2 * i));
    end
    return l;
  endfunction

  task automatic report_mismatch(string what, logic [31:0] exp_v, logic [31:0] act_v);
    $display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp_v, act_v);
    errors++;
  endtask

  //////////////////////////////////////////////////////////////
  // per-cycle memory model and checks
  //////////////////////////////////////////////////////////////

  task automatic observe_memory();
    int unsigned due;
    if (mem_rsp_i.rvalid) begin
      if (pend_id[0] == stream_id && !branch_i) held++;  // line enters the queue
      pend_line.delete(0);
      pend_due.delete(0);
      pend_id.delete(0);
    end
    if (mem_req_o.req && mem_rsp_i.gnt) begin
      checks++;
      if (mem_req_o.line_addr !== exp_req_line) begin
        report_mismatch("request line", exp_req_line, mem_req_o.line_addr);
      end
      exp_req_line = exp_req_line + 1'b1;   // lines follow in order
      due = cycle + ($urandom % (cur_lat + 1));
      if (pend_due.size() > 0 && due <= pend_due[pend_due.size() - 1]) begin
        due = pend_due[pend_due.size() - 1] + 1;  // keep responses in order
      end
      pend_line.push_back(mem_req_o.line_addr);
      pend_due.push_back(due);
      pend_id.push_back(stream_id);
      gnt_wait = $urandom % (cur_lat + 1);
    end else if (mem_req_o.req && gnt_wait > 0) begin
      gnt_wait--;
    end
  endtask

  task automatic check_fetch();
    rv_instr_pkg::hword_t  lo;
    rv_instr_pkg::instr_t  exp_data;
    fetch_geom_pkg::addr_t nxt;
    int unsigned           act_len;
    if (!armed && (mem_req_o.req || fetch_o.valid || busy_o)) begin
      $display("Error: request, valid or busy raised before the first branch");
      errors++;
    end
    if (hold_prev && !branch_i) begin
      checks++;
      if (!fetch_o.valid) begin
        $display("Error: valid dropped without a transfer in test %s", cur_name);
        errors++;
      end
      if (fetch_o.data !== fetch_prev.data) begin
        report_mismatch("held data", fetch_prev.data, fetch_o.data);
      end
      if (fetch_o.addr !== fetch_prev.addr) begin
        report_mismatch("held addr", fetch_prev.addr, fetch_o.addr);
      end
    end
    if (fetch_o.valid && ready_i) begin
      lo = image_hword(exp_pc);
      if (lo[1:0] == rv_instr_pkg::OPC_FULL) begin
        exp_data = {image_hword(exp_pc + 2), lo};
        nxt      = exp_pc + 4;
      end else begin
        exp_data = {16'h0000, lo};
        nxt      = exp_pc + 2;
      end
      act_len = (fetch_o.data[1:0] == rv_instr_pkg::OPC_FULL) ? 4 : 2;
      checks += 2;
      if (fetch_o.addr !== exp_pc) report_mismatch("addr", exp_pc, fetch_o.addr);
      if (fetch_o.data !== exp_data) report_mismatch("data", exp_data, fetch_o.data);
      if (first_xfer) begin
        checks++;
        if (act_len != cur_first_len) report_mismatch("first length", cur_first_len, act_len);
      end
      if (nxt[31:4] != exp_pc[31:4]) held--;   // head line is left
      exp_pc     = nxt;
      accepted++;
      first_xfer = 1'b0;
    end
    checks++;
    if (pend_line.size() + held > fetch_geom_pkg::QUEUE_DEPTH) begin
      $display("Error: %0d requests outstanding and %0d lines held exceed the queue in test %s",
               pend_line.size(), held, cur_name);
      errors++;
    end
    hold_prev  = fetch_o.valid && !ready_i;
    fetch_prev = fetch_o;
    busy_seen  = busy_o;
    if (branch_i) begin
      armed        = 1'b1;
      exp_pc       = branch_addr_i;
      exp_req_line = branch_addr_i[31:4];
      accepted     = 0;
      held         = 0;
      first_xfer   = 1'b1;
      stream_id++;
    end
  endtask

  task automatic drive_inputs();
    fetch_geom_pkg::mem_rsp_t rsp;
    rsp     = '0;
    rsp.gnt = (gnt_wait == 0);
    if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
      rsp.rvalid = 1'b1;
      rsp.rdata  = line_data(pend_line[0]);
    end
    mem_rsp_i <= rsp;
    ready_i   <= (accepted < cur_count) && (($urandom % 100) < cur_pct);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    cycle++;
    observe_memory();   // grants of a branch cycle still belong to the old stream
    check_fetch();
    drive_inputs();
  endtask

  //////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////

  initial begin
    int unsigned seed;
    int unsigned n;
    clk           = 1'b0;
    rst_n         = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    ready_i       = 1'b0;
    mem_rsp_i     = '0;
    cycle         = 0;
    errors        = 0;
    checks        = 0;
    cur_name      = "reset";
    cur_count     = 0;
    cur_pct       = 0;
    cur_lat       = 0;
    cur_first_len = 0;
    armed         = 1'b0;
    exp_pc        = '0;
    exp_req_line  = '0;
    accepted      = 0;
    held          = 0;
    first_xfer    = 1'b0;
    stream_id     = 0;
    hold_prev     = 1'b0;
    fetch_prev    = '0;
    busy_seen     = 1'b0;
    gnt_wait      = 0;
    seed          = $urandom(32'h2f81);
    repeat (2) next_cycle();
    rst_n <= 1'b1;
    repeat (10) next_cycle();   // idle until the first branch
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur_name      = row_names[r];
      cur_count     = rows[r].count;
      cur_pct       = rows[r].ready_pct;
      cur_lat       = rows[r].lat;
      cur_first_len = rows[r].first_len;
      branch_addr_i <= rows[r].target;
      branch_i      <= 1'b1;
      next_cycle();
      branch_i      <= 1'b0;
      while (accepted < cur_count) next_cycle();
      if (rows[r].stall) begin
        n = 0;
        while (busy_seen && n < 8 * (cur_lat + 4)) begin   // queue fills, requests stop
          next_cycle();
          n++;
        end
        checks++;
        if (busy_seen) begin
          $display("Error: busy_o still high with the stream stalled in test %s", cur_name);
          errors++;
        end
      end
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the longest row and the slowest memory
  initial begin
    int unsigned max_n;
    int unsigned max_lat;
    int unsigned limit_ns;
    max_n   = 0;
    max_lat = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].count > max_n) max_n = rows[r].count;
      if (rows[r].lat > max_lat) max_lat = rows[r].lat;
    end
    limit_ns = NUM_ROWS * max_n * (max_lat + 4) * 4 * 4;
    #(limit_ns);
    $display("Error: watchdog expired after %0d ns in test %s", limit_ns, cur_name);
    $display("%0d checks, %0d errors", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: src.f
src/fetch_geom_pkg.sv
src/rv_instr_pkg.sv
src/line_fetch_ctrl.sv
src/line_queue.sv
src/instr_aligner.sv
src/prefetch_buffer.sv
testbench/tb_prefetch_buffer.sv
